/* axi_refill_pkg.sv */
`default_nettype none

package axi_refill_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;

    // cache line geometry, 16 bytes per line
    localparam int line_beats    = 4;
    localparam int line_w        = line_beats * data_w;
    localparam int line_offset_w = 4;

    // arid values, one per requester
    localparam logic [id_w-1:0] src_icache   = 4'd0;
    localparam logic [id_w-1:0] src_dcache   = 4'd1;
    localparam logic [id_w-1:0] src_uncached = 4'd2;

    // AXI size / burst codes
    localparam logic [2:0] axsize_word  = 3'b010; // 4 bytes
    localparam logic [1:0] axburst_incr = 2'b01;

    // one captured R beat
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic              last;
    } rbeat_t;

endpackage

`default_nettype wire

/* axi_read_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_issue
    import axi_refill_pkg::*;
(
    input  wire logic              aclk,
    input  wire logic              arst_n,
    input  wire logic              icache_rd_req,
    input  wire logic [addr_w-1:0] icache_rd_addr,
    output logic                   icache_rd_rdy,
    input  wire logic              dcache_rd_req,
    input  wire logic [addr_w-1:0] dcache_rd_addr,
    output logic                   dcache_rd_rdy,
    input  wire logic              uncached_rd_req,
    input  wire logic [addr_w-1:0] uncached_rd_addr,
    output logic                   uncached_rd_rdy,
    output logic [id_w-1:0]        arid,
    output logic [addr_w-1:0]      araddr,
    output logic [3:0]             arlen,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,
    output logic                   arvalid,
    input  wire logic              arready,
    input  wire logic              rd_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_wait
    } state_t;

    state_t            state;
    logic              any_req;
    logic [id_w-1:0]   win_id;
    logic [addr_w-1:0] win_addr;
    logic              win_line;    // refill rather than single word
    logic              take;

    assign any_req = icache_rd_req | dcache_rd_req | uncached_rd_req;
    assign take    = (state == st_idle) && any_req;

    // fixed priority dcache then uncached then icache
    always_comb begin
        win_id   = src_icache;
        win_addr = icache_rd_addr;
        win_line = 1'b1;
        if (dcache_rd_req) begin
            win_id   = src_dcache;
            win_addr = dcache_rd_addr;
        end else if (uncached_rd_req) begin
            win_id   = src_uncached;
            win_addr = uncached_rd_addr;
            win_line = 1'b0;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (any_req) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (arready) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (rd_done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            arid <= win_id;
            if (win_line) begin
                araddr <= {win_addr[addr_w-1:line_offset_w], {line_offset_w{1'b0}}};
                arlen  <= 4'(line_beats - 1);
            end else begin
                araddr <= win_addr;
                arlen  <= 4'd0;
            end
        end
    end

    assign arsize  = axsize_word;
    assign arburst = axburst_incr;
    assign arvalid = (state == st_addr);

    assign icache_rd_rdy   = (state == st_idle);
    assign dcache_rd_rdy   = (state == st_idle);
    assign uncached_rd_rdy = (state == st_idle);

endmodule

`default_nettype wire

/* rbeat_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module rbeat_capture
    import axi_refill_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  wire logic              aclk,
    input  wire logic              arst_n,
    input  wire logic [id_w-1:0]   rid,
    input  wire logic [data_w-1:0] rdata,
    input  wire logic              rlast,
    input  wire logic              rvalid,
    output logic                   rready,
    output logic                   push_valid,
    output rbeat_t                 push_beat,
    input  wire logic              credit_return
);

    localparam int credit_w = $clog2(fifo_depth + 1);

    logic [credit_w-1:0] credits;
    logic                accept;

    assign rready = (credits != '0);
    assign accept = rvalid & rready;

    // credit is spent when the beat is taken, so an in-flight beat holds its slot
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= credit_w'(fifo_depth);
        end else begin
            credits <= credits + credit_w'(credit_return) - credit_w'(accept);
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            push_valid <= 1'b0;
        end else begin
            push_valid <= accept;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            push_beat.id   <= rid;
            push_beat.data <= rdata;
            push_beat.last <= rlast;
        end
    end

endmodule

`default_nettype wire

/* rbeat_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module rbeat_fifo
    import axi_refill_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  wire logic   aclk,
    input  wire logic   arst_n,
    input  wire logic   push_valid,
    input  wire rbeat_t push_beat,
    input  wire logic   pop,
    output logic        head_valid,
    output rbeat_t      head_beat,
    output logic        credit_return
);

    localparam int ptr_w   = $clog2(fifo_depth);
    localparam int count_w = $clog2(fifo_depth + 1);

    rbeat_t             mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [count_w-1:0] count;
    logic               do_pop;

    assign head_valid = (count != '0);
    assign head_beat  = mem[rd_ptr];
    assign do_pop     = pop & head_valid;

    // each beat leaving frees one slot upstream
    assign credit_return = do_pop;

    always_ff @(posedge aclk) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_valid) begin
                if (wr_ptr == ptr_w'(fifo_depth - 1)) begin
                    wr_ptr <= '0; // depth need not be a power of two
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == ptr_w'(fifo_depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            count <= count + count_w'(push_valid) - count_w'(do_pop);
        end
    end

endmodule

`default_nettype wire

/* line_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module line_assembler
    import axi_refill_pkg::*;
(
    input  wire logic          aclk,
    input  wire logic          arst_n,
    input  wire logic          head_valid,
    input  wire rbeat_t        head_beat,
    output logic               pop,
    output logic               rd_done,
    output logic               icache_ret_valid,
    output logic [line_w-1:0]  icache_ret_data,
    output logic               dcache_ret_valid,
    output logic [line_w-1:0]  dcache_ret_data,
    output logic               uncached_ret_valid,
    output logic [data_w-1:0]  uncached_ret_data
);

    localparam int cnt_w = $clog2(line_beats);

    logic [cnt_w-1:0]  beat_cnt;
    logic [line_w-1:0] line_q;
    logic [line_w-1:0] line_next;
    logic              done;

    // drain the fifo every cycle it has something
    assign pop  = head_valid;
    assign done = pop & head_beat.last;

    // current beat merged in so the last beat is part of the return
    always_comb begin
        line_next = line_q;
        line_next[beat_cnt*data_w +: data_w] = head_beat.data;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt <= '0;
        end else if (pop) begin
            if (head_beat.last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            line_q <= line_next;
        end
    end

    assign rd_done = done;

    // route by id
    assign icache_ret_valid   = done && (head_beat.id == src_icache);
    assign dcache_ret_valid   = done && (head_beat.id == src_dcache);
    assign uncached_ret_valid = done && (head_beat.id == src_uncached);

    assign icache_ret_data   = line_next;
    assign dcache_ret_data   = line_next;
    assign uncached_ret_data = head_beat.data; // single word passed as is

endmodule

`default_nettype wire

/* axi_refill_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_refill_bridge
    import axi_refill_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  wire logic              aclk,
    input  wire logic              arst_n,
    // instruction cache
    input  wire logic              icache_rd_req,
    input  wire logic [addr_w-1:0] icache_rd_addr,
    output logic                   icache_rd_rdy,
    output logic                   icache_ret_valid,
    output logic [line_w-1:0]      icache_ret_data,
    // data cache
    input  wire logic              dcache_rd_req,
    input  wire logic [addr_w-1:0] dcache_rd_addr,
    output logic                   dcache_rd_rdy,
    output logic                   dcache_ret_valid,
    output logic [line_w-1:0]      dcache_ret_data,
    // uncached word path
    input  wire logic              uncached_rd_req,
    input  wire logic [addr_w-1:0] uncached_rd_addr,
    output logic                   uncached_rd_rdy,
    output logic                   uncached_ret_valid,
    output logic [data_w-1:0]      uncached_ret_data,
    // AXI AR
    output logic [id_w-1:0]        arid,
    output logic [addr_w-1:0]      araddr,
    output logic [3:0]             arlen,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,
    output logic                   arvalid,
    input  wire logic              arready,
    // AXI R
    input  wire logic [id_w-1:0]   rid,
    input  wire logic [data_w-1:0] rdata,
    input  wire logic              rlast,
    input  wire logic              rvalid,
    output logic                   rready
);

    logic   rd_done;
    logic   push_valid;
    rbeat_t push_beat;
    logic   credit_return;
    logic   head_valid;
    rbeat_t head_beat;
    logic   pop;

    axi_read_issue u_issue (
        .aclk             (aclk            ),
        .arst_n           (arst_n          ),
        .icache_rd_req    (icache_rd_req   ),
        .icache_rd_addr   (icache_rd_addr  ),
        .icache_rd_rdy    (icache_rd_rdy   ),
        .dcache_rd_req    (dcache_rd_req   ),
        .dcache_rd_addr   (dcache_rd_addr  ),
        .dcache_rd_rdy    (dcache_rd_rdy   ),
        .uncached_rd_req  (uncached_rd_req ),
        .uncached_rd_addr (uncached_rd_addr),
        .uncached_rd_rdy  (uncached_rd_rdy ),
        .arid             (arid            ),
        .araddr           (araddr          ),
        .arlen            (arlen           ),
        .arsize           (arsize          ),
        .arburst          (arburst         ),
        .arvalid          (arvalid         ),
        .arready          (arready         ),
        .rd_done          (rd_done         )
    );

    rbeat_capture #(
        .fifo_depth (fifo_depth)
    ) u_capture (
        .aclk          (aclk         ),
        .arst_n        (arst_n       ),
        .rid           (rid          ),
        .rdata         (rdata        ),
        .rlast         (rlast        ),
        .rvalid        (rvalid       ),
        .rready        (rready       ),
        .push_valid    (push_valid   ),
        .push_beat     (push_beat    ),
        .credit_return (credit_return)
    );

    rbeat_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .aclk          (aclk         ),
        .arst_n        (arst_n       ),
        .push_valid    (push_valid   ),
        .push_beat     (push_beat    ),
        .pop           (pop          ),
        .head_valid    (head_valid   ),
        .head_beat     (head_beat    ),
        .credit_return (credit_return)
    );

    line_assembler u_assembler (
        .aclk               (aclk              ),
        .arst_n             (arst_n            ),
        .head_valid         (head_valid        ),
        .head_beat          (head_beat         ),
        .pop                (pop               ),
        .rd_done            (rd_done           ),
        .icache_ret_valid   (icache_ret_valid  ),
        .icache_ret_data    (icache_ret_data   ),
        .dcache_ret_valid   (dcache_ret_valid  ),
        .dcache_ret_data    (dcache_ret_data   ),
        .uncached_ret_valid (uncached_ret_valid),
        .uncached_ret_data  (uncached_ret_data )
    );

endmodule

`default_nettype wire

/* tb_axi_refill_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_refill_bridge
    import axi_refill_pkg::*;
();

    localparam int n_random       = 200;
    localparam int n_requests     = 6 + n_random;
    localparam int timeout_cycles = n_requests * 40 + 200;

    logic              aclk;
    logic              arst_n;
    logic              icache_rd_req, dcache_rd_req, uncached_rd_req;
    logic [addr_w-1:0] icache_rd_addr, dcache_rd_addr, uncached_rd_addr;
    logic              icache_rd_rdy, dcache_rd_rdy, uncached_rd_rdy;
    logic              icache_ret_valid, dcache_ret_valid, uncached_ret_valid;
    logic [line_w-1:0] icache_ret_data, dcache_ret_data;
    logic [data_w-1:0] uncached_ret_data;
    logic [id_w-1:0]   arid, rid;
    logic [addr_w-1:0] araddr;
    logic [3:0]        arlen;
    logic [2:0]        arsize;
    logic [1:0]        arburst;
    logic              arvalid, arready;
    logic [data_w-1:0] rdata;
    logic              rlast, rvalid, rready;

    int                errors;
    int                tests_run;
    int                tests_failed;
    int                err_base;
    int                cycles;
    int                exp_src;
    logic              checking;
    int                order_q[$];        // sources in acceptance order
    logic [39:0]       exp_ar_q[$];       // {arid, arlen, araddr}
    logic [line_w-1:0] exp_icache_q[$];
    logic [line_w-1:0] exp_dcache_q[$];
    logic [data_w-1:0] exp_uncached_q[$];

    axi_refill_bridge i_dut (.*);

    always #4 aclk = ~aclk;

    function automatic logic [data_w-1:0] ref_word(input logic [addr_w-1:0] addr);
        return addr ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [line_w-1:0] ref_line(input logic [addr_w-1:0] addr);
        logic [line_w-1:0] line;
        logic [addr_w-1:0] base;
        base = {addr[addr_w-1:4], 4'h0};
        for (int k = 0; k < 4; k++) begin
            line[k*32 +: 32] = ref_word(base + 4 * k); // word 0 in the low bits
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [line_w-1:0] exp,
                               input logic [line_w-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic raise_req(input int src, input logic [addr_w-1:0] addr);
        case (src)
            0: begin
                icache_rd_req  = 1'b1;
                icache_rd_addr = addr;
            end
            1: begin
                dcache_rd_req  = 1'b1;
                dcache_rd_addr = addr;
            end
            default: begin
                uncached_rd_req  = 1'b1;
                uncached_rd_addr = addr;
            end
        endcase
    endtask

    // waits until the bridge takes this source, then drops its request
    task automatic wait_taken(input int src);
        logic              taken;
        logic [addr_w-1:0] addr;
        taken = 1'b0;
        while (!taken) begin
            @(negedge aclk);
            case (src)
                0: taken = icache_rd_rdy && !dcache_rd_req && !uncached_rd_req;
                1: taken = dcache_rd_rdy;
                default: taken = uncached_rd_rdy && !dcache_rd_req;
            endcase
        end
        @(posedge aclk);
        #1;
        case (src)
            0: begin
                addr          = icache_rd_addr;
                icache_rd_req = 1'b0;
                exp_icache_q.push_back(ref_line(addr));
            end
            1: begin
                addr          = dcache_rd_addr;
                dcache_rd_req = 1'b0;
                exp_dcache_q.push_back(ref_line(addr));
            end
            default: begin
                addr            = uncached_rd_addr;
                uncached_rd_req = 1'b0;
                exp_uncached_q.push_back(ref_word(addr));
            end
        endcase
        order_q.push_back(src);
        if (src == 2) begin
            exp_ar_q.push_back({4'd2, 4'd0, addr}); // single word, address as given
        end else begin
            exp_ar_q.push_back({4'(src), 4'd3, addr[31:4], 4'h0});
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (order_q.size() != 0 && n < limit) begin
            @(negedge aclk);
            n++;
        end
        @(posedge aclk);
        #1;
        if (order_q.size() != 0) begin
            $display("missing return: %0d request(s) got no ret_valid", order_q.size());
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d error(s)", tests_run, name, errors - err_base);
        end
        err_base = errors;
    endtask

    // AXI slave, one burst at a time
    task automatic serve_read();
        logic [39:0]       exp_ar;
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [3:0]        len;
        int                gap;
        @(negedge aclk);
        while (!arvalid) begin
            @(negedge aclk);
        end
        gap = $urandom_range(3);
        repeat (gap) begin
            @(negedge aclk);
            check_value("arvalid", 1'b1, arvalid); // held until accepted
        end
        @(posedge aclk);
        #1;
        arready = 1'b1;
        @(negedge aclk);
        check_value("arvalid", 1'b1, arvalid);
        id   = arid;
        addr = araddr;
        len  = arlen;
        if (exp_ar_q.size() == 0) begin
            $display("an AR request was issued with no request accepted");
            errors++;
        end else begin
            exp_ar = exp_ar_q.pop_front();
            check_value("arid", exp_ar[39:36], id);
            check_value("arlen", exp_ar[35:32], len);
            check_value("araddr", exp_ar[31:0], addr);
        end
        check_value("arsize", 3'b010, arsize);
        check_value("arburst", 2'b01, arburst);
        @(posedge aclk);
        #1;
        arready = 1'b0;
        for (int k = 0; k <= len; k++) begin
            gap = $urandom_range(3);
            repeat (gap) @(posedge aclk);
            #1;
            rvalid = 1'b1;
            rid    = id;
            rdata  = ref_word(addr + 4 * k);
            rlast  = (k == len);
            @(negedge aclk);
            while (!rready) begin
                @(negedge aclk);
            end
            @(posedge aclk);
            #1;
            rvalid = 1'b0;
        end
    endtask

    initial begin
        @(posedge arst_n);
        forever serve_read();
    end

    // rdy and return checks on the falling edge, where outputs are settled
    always @(negedge aclk) begin
        if (checking) begin
            check_value("icache_rd_rdy", order_q.size() == 0, icache_rd_rdy);
            check_value("dcache_rd_rdy", order_q.size() == 0, dcache_rd_rdy);
            check_value("uncached_rd_rdy", order_q.size() == 0, uncached_rd_rdy);
            if ($countones({icache_ret_valid, dcache_ret_valid, uncached_ret_valid}) > 1) begin
                $display("more than one ret_valid in the same cycle");
                errors++;
            end else if (icache_ret_valid || dcache_ret_valid || uncached_ret_valid) begin
                if (order_q.size() == 0) begin
                    $display("a return arrived with no request outstanding");
                    errors++;
                end else begin
                    exp_src = order_q.pop_front();
                    check_value("ret_source", exp_src,
                                icache_ret_valid ? 0 : (dcache_ret_valid ? 1 : 2));
                    case (exp_src)
                        0: check_value("icache_ret_data", exp_icache_q.pop_front(),
                                       icache_ret_data);
                        1: check_value("dcache_ret_data", exp_dcache_q.pop_front(),
                                       dcache_ret_data);
                        default: check_value("uncached_ret_data", exp_uncached_q.pop_front(),
                                             uncached_ret_data);
                    endcase
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, %0d request(s) still waiting for a return",
                     cycles, order_q.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int                seed;
        int                src;
        logic [addr_w-1:0] addr;
        aclk             = 1'b0;
        arst_n           = 1'b0;
        icache_rd_req    = 1'b0;
        dcache_rd_req    = 1'b0;
        uncached_rd_req  = 1'b0;
        icache_rd_addr   = '0;
        dcache_rd_addr   = '0;
        uncached_rd_addr = '0;
        arready          = 1'b0;
        rid              = '0;
        rdata            = '0;
        rlast            = 1'b0;
        rvalid           = 1'b0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;
        err_base         = 0;
        cycles           = 0;
        checking         = 1'b0;
        seed             = 2913;
        void'($urandom(seed));
        repeat (5) @(posedge aclk);
        #1;
        arst_n = 1'b1;

        @(negedge aclk);
        check_value("icache_rd_rdy", 1'b1, icache_rd_rdy);
        check_value("dcache_rd_rdy", 1'b1, dcache_rd_rdy);
        check_value("uncached_rd_rdy", 1'b1, uncached_rd_rdy);
        check_value("arvalid", 1'b0, arvalid);
        check_value("rready", 1'b1, rready);
        check_value("icache_ret_valid", 1'b0, icache_ret_valid);
        check_value("dcache_ret_valid", 1'b0, dcache_ret_valid);
        check_value("uncached_ret_valid", 1'b0, uncached_ret_valid);
        checking = 1'b1;
        end_test("reset state");

        @(posedge aclk);
        #1;
        raise_req(0, 32'h1000_0128); // mid-line address
        wait_taken(0);
        wait_idle(40);
        end_test("icache refill");

        raise_req(1, 32'h2000_3A34);
        wait_taken(1);
        wait_idle(40);
        end_test("dcache refill");

        raise_req(2, 32'hBFC0_0104);
        wait_taken(2);
        wait_idle(40);
        end_test("uncached word");

        raise_req(0, 32'h0000_4444);
        raise_req(1, 32'h0000_8888);
        raise_req(2, 32'h0000_CCCC);
        wait_taken(1);
        wait_taken(2);
        wait_taken(0);
        wait_idle(120);
        end_test("priority order");

        for (int i = 0; i < n_random; i++) begin
            src  = $urandom_range(2);
            addr = $urandom();
            if (src == 2) begin
                addr[1:0] = 2'b00;
            end
            repeat ($urandom_range(2)) @(posedge aclk);
            #1;
            raise_req(src, addr);
            wait_taken(src);
        end
        wait_idle(80);
        end_test("random requests");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* axi_refill_bridge.f */
axi_refill_pkg.sv
axi_read_issue.sv
rbeat_capture.sv
rbeat_fifo.sv
line_assembler.sv
axi_refill_bridge.sv
tb_axi_refill_bridge.sv

/* Bender.yml */
package:
  name: axi_refill_bridge

sources:
  - files:
      - axi_refill_pkg.sv
      - axi_read_issue.sv
      - rbeat_capture.sv
      - rbeat_fifo.sv
      - line_assembler.sv
      - axi_refill_bridge.sv
  - target: test
    files:
      - tb_axi_refill_bridge.sv
